//--- layerScan.sv
/*
 * One layer scanner. Applies the layer's scroll to the render position and
 * draws an arithmetic pattern in place of tile memory.
 * Colour is registered on cen, one step after the hdump/vrender it used.
 */
`default_nettype none

module layerScan #(
    parameter int LAYER_ID = 0
) (
    input  wire                          clk,
    input  wire                          rstN,
    input  wire                          cen,
    input  wire  [videoPkg::CNT_W-1:0]   hdump,
    input  wire  [videoPkg::CNT_W-1:0]   vrender,
    input  wire  [videoPkg::CNT_W-1:0]   hScroll,
    input  wire  [videoPkg::CNT_W-1:0]   vScroll,
    output logic [videoPkg::COL_W-1:0]   colour
);

    // scrolled position, modulo 512 by width
    logic [videoPkg::CNT_W-1:0] scrX;
    logic [videoPkg::CNT_W-1:0] scrY;
    logic [videoPkg::COL_W-1:0] pattern;

    assign scrX = hdump + hScroll;
    assign scrY = vrender + vScroll;

    // checker of x xor y, offset per layer so layers differ
    // a zero result is simply a transparent pixel
    assign pattern = (scrX[videoPkg::COL_W-1:0] ^ scrY[videoPkg::COL_W-1:0])
                   + videoPkg::COL_W'(LAYER_ID);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            colour <= videoPkg::TRANSPARENT;
        end else if (cen) begin
            colour <= pattern;
        end
    end

endmodule

`default_nettype wire

//--- pixelMixer.sv
/*
 * Final pixel mixer. Walks the priority order front to back, keeps the first
 * opaque layer and outputs {layer, colour}; blank outside the active area.
 * Registered on cen with HB/VB delayed alongside to stay aligned.
 */
`default_nettype none

module pixelMixer #(
    parameter int NUM_LAYERS = 3
) (
    input  wire                                             clk,
    input  wire                                             rstN,
    input  wire                                             cen,
    input  wire  [NUM_LAYERS-1:0][videoPkg::COL_W-1:0]      colour,
    input  wire  [NUM_LAYERS-1:0][videoPkg::LAYER_W-1:0]    priorityOrder,
    input  wire                                             HB,
    input  wire                                             VB,
    output logic [videoPkg::PIX_W-1:0]                      pixel,
    output logic                                            pixelLayerOk,
    output logic                                            HBout,
    output logic                                            VBout
);

    logic [videoPkg::LAYER_W-1:0] selLayer;
    logic [videoPkg::COL_W-1:0]   selColour;
    logic                         selOk;

    // back to front so the front-most opaque layer is written last
    always_comb begin
        selLayer  = '0;
        selColour = videoPkg::TRANSPARENT;
        selOk     = 1'b0;
        for (int s = NUM_LAYERS - 1; s >= 0; s--) begin
            if (colour[priorityOrder[s]] != videoPkg::TRANSPARENT) begin
                selLayer  = priorityOrder[s];
                selColour = colour[priorityOrder[s]];
                selOk     = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pixel        <= videoPkg::BLANK_PIX;
            pixelLayerOk <= 1'b0;
            HBout        <= 1'b1;
            VBout        <= 1'b1;
        end else if (cen) begin
            // HB/VB here already match the scanner colours
            HBout <= HB;
            VBout <= VB;
            if (HB || VB || !selOk) begin
                pixel        <= videoPkg::BLANK_PIX;
                pixelLayerOk <= 1'b0;
            end else begin
                pixel        <= {selLayer, selColour};
                pixelLayerOk <= 1'b1;
            end
        end
    end

    // an accepted layer never shows the transparent code
    okHasColour: assert property (
        @(posedge clk) disable iff (!rstN)
        pixelLayerOk |-> pixel[videoPkg::COL_W-1:0] != videoPkg::TRANSPARENT
    ) else $error("pixelLayerOk with a transparent colour");

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the video testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tbVideoTop --Mdir "$BUILD_DIR" -o simv
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/simv" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if [ $simStatus -eq 0 ] && grep -qx "STATUS: PASS" "$LOG"; then
    exit 0
fi
echo "simulation failed, exit status $simStatus"
exit 1

//--- scrollRegs.sv
/*
 * Scroll and priority register bank.
 * One hScroll and one vScroll word per layer plus the layer priority order,
 * written by a single-cycle strobe; the new value shows on the next clk.
 */
`default_nettype none

module scrollRegs #(
    parameter int NUM_LAYERS = 3
) (
    input  wire                                                 clk,
    input  wire                                                 rstN,
    input  wire                                                 wrEn,
    input  wire  [videoPkg::LAYER_W-1:0]                        wrLayer,
    input  wire  [videoPkg::SEL_W-1:0]                          wrSel,
    input  wire  [videoPkg::CNT_W-1:0]                          wrData,
    output logic [NUM_LAYERS-1:0][videoPkg::CNT_W-1:0]          hScroll,
    output logic [NUM_LAYERS-1:0][videoPkg::CNT_W-1:0]          vScroll,
    output logic [NUM_LAYERS-1:0][videoPkg::LAYER_W-1:0]        priorityOrder
);

    logic [NUM_LAYERS-1:0][videoPkg::LAYER_W-1:0] newOrder;
    logic layerOk;
    logic orderOk;

    assign layerOk = int'(wrLayer) < NUM_LAYERS;

    // unpack one index per slot, slot 0 in the low bits
    always_comb begin
        orderOk = 1'b1;
        for (int s = 0; s < NUM_LAYERS; s++) begin
            newOrder[s] = wrData[s*videoPkg::LAYER_W +: videoPkg::LAYER_W];
            if (int'(newOrder[s]) >= NUM_LAYERS) begin
                orderOk = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hScroll <= '0;
            vScroll <= '0;
            // identity order, layer 0 in front
            for (int s = 0; s < NUM_LAYERS; s++) begin
                priorityOrder[s] <= videoPkg::LAYER_W'(s);
            end
        end else if (wrEn) begin
            case (wrSel)
                videoPkg::SEL_HSCROLL: begin
                    if (layerOk) hScroll[wrLayer] <= wrData;
                end
                videoPkg::SEL_VSCROLL: begin
                    if (layerOk) vScroll[wrLayer] <= wrData;
                end
                // a bad index anywhere drops the whole order
                videoPkg::SEL_PRIORITY: begin
                    if (orderOk) priorityOrder <= newOrder;
                end
                default: ;
            endcase
        end
    end

    // mixer relies on every slot naming a real scanner
    for (genvar s = 0; s < NUM_LAYERS; s++) begin : gPrioCheck
        prioInRange: assert property (
            @(posedge clk) disable iff (!rstN)
            int'(priorityOrder[s]) < NUM_LAYERS
        ) else $error("priority slot %0d holds an invalid layer", s);
    end

endmodule

`default_nettype wire

//--- tb.f
videoPkg.sv
videoTiming.sv
scrollRegs.sv
layerScan.sv
pixelMixer.sv
videoTop.sv
tbVideoTop.sv

//--- tbVideoTop.sv
/*
 * Self-checking testbench for videoTop.
 * Random cen and random scroll/priority writes from a fixed seed; a cycle
 * model of the timing, scanners and mixer is compared with the DUT after
 * every clock edge. Runs for two full frames of cen steps.
 */
`default_nettype none

module tbVideoTop;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_LAYERS = 3;
    // two frames of pixel steps
    localparam int RUN_STEPS = 2 * videoPkg::H_TOTAL * int'(videoPkg::V_TOTAL);
    // ~358k cycles at a 3/4 cen rate, plus margin
    localparam int TIMEOUT_CYCLES = 400000;

    logic clk;
    logic rstN;
    logic cen;
    logic wrEn;
    logic [videoPkg::LAYER_W-1:0] wrLayer;
    logic [videoPkg::SEL_W-1:0]   wrSel;
    logic [videoPkg::CNT_W-1:0]   wrData;
    logic [videoPkg::CNT_W-1:0]   hdump;
    logic [videoPkg::CNT_W-1:0]   vdump;
    logic [videoPkg::CNT_W-1:0]   vrender;
    logic HS;
    logic VS;
    logic HB;
    logic VB;
    logic [videoPkg::PIX_W-1:0]   pixel;
    logic pixelLayerOk;

    int seed = 32'h3483;
    int cycleCount = 0;
    int cenSteps = 0;

    // model state, reset values of the design
    int mH = 0;
    int mV = 0;
    int mHS = 0;
    int mVS = 0;
    // blanking as it leaves the timing generator
    int mHBt = 1;
    int mVBt = 1;
    // port values one step behind
    int expHB = 1;
    int expVB = 1;
    int expPix = 0;
    int expOk = 0;
    int mCol [NUM_LAYERS] = '{default: 0};
    int mHs [NUM_LAYERS] = '{default: 0};
    int mVs [NUM_LAYERS] = '{default: 0};
    int mPrio [NUM_LAYERS] = '{0, 1, 2};

    videoTop #(
        .NUM_LAYERS (NUM_LAYERS)
    ) i_dut (
        .clk          (clk),
        .rstN         (rstN),
        .cen          (cen),
        .wrEn         (wrEn),
        .wrLayer      (wrLayer),
        .wrSel        (wrSel),
        .wrData       (wrData),
        .hdump        (hdump),
        .vdump        (vdump),
        .vrender      (vrender),
        .HS           (HS),
        .VS           (VS),
        .HB           (HB),
        .VB           (VB),
        .pixel        (pixel),
        .pixelLayerOk (pixelLayerOk)
    );

    always #20 clk = ~clk;

    // watchdog
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timeout: %0d cen steps done after %0d cycles", cenSteps, cycleCount);
            $display("STATUS: FAIL");
            $fatal(1, "run did not finish in time");
        end
    end

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch %s: got 0x%0h expected 0x%0h (cen step %0d)",
                     name, got, expected, cenSteps);
            $display("STATUS: FAIL");
            $fatal(1, "output check failed");
        end
    endtask

    function automatic int hBlank(int h);
        return int'(h >= int'(videoPkg::HB_START) || h < int'(videoPkg::HB_END));
    endfunction

    function automatic int vPreBlank(int v);
        return int'(v < int'(videoPkg::VB_FIRST) || v > int'(videoPkg::VB_LAST));
    endfunction

    // following line, wrapping at the frame end
    function automatic int nextLine(int v);
        return (v + 1) % int'(videoPkg::V_TOTAL);
    endfunction

    // x xor y on the low nibble, offset by the layer number
    function automatic int patternColour(int layer, int h, int r, int hs, int vs);
        int x;
        int y;
        x = (h + hs) % 512;
        y = (r + vs) % 512;
        return (((x ^ y) % 16) + layer) % 16;
    endfunction

    // one clk edge of the model, inputs as the DUT sees them
    task automatic stepModel();
        int found;
        int pixLayer;
        int pixCol;
        int ok;
        int idx;
        int render;
        int newOrder [NUM_LAYERS];
        found = 0;
        pixLayer = 0;
        pixCol = 0;
        // render line runs one ahead of the dump line
        render = nextLine(mV);
        if (cen) begin
            cenSteps++;
            // mixer stage on last step's colours, front slot first
            for (int s = 0; s < NUM_LAYERS; s++) begin
                if (found == 0 && mCol[mPrio[s]] != 0) begin
                    found = 1;
                    pixLayer = mPrio[s];
                    pixCol = mCol[mPrio[s]];
                end
            end
            expHB = mHBt;
            expVB = mVBt;
            if (mHBt != 0 || mVBt != 0 || found == 0) begin
                expPix = int'(videoPkg::BLANK_PIX);
                expOk = 0;
            end else begin
                expPix = (pixLayer << videoPkg::COL_W) | pixCol;
                expOk = 1;
            end
            // scanner stage
            for (int l = 0; l < NUM_LAYERS; l++) begin
                mCol[l] = patternColour(l, mH, render, mHs[l], mVs[l]);
            end
            mHBt = hBlank(mH);
            if (mH == int'(videoPkg::HS_START)) begin
                mHS = 1;
                if (mV == int'(videoPkg::VS_START)) mVS = 1;
                if (mV == int'(videoPkg::VS_END)) mVS = 0;
            end
            if (mH == int'(videoPkg::HS_END)) mHS = 0;
            if (mH == videoPkg::H_TOTAL - 1) begin
                mV = nextLine(mV);
            end
            mH = (mH + 1) % videoPkg::H_TOTAL;
            // pre-blank flag two line wraps late
            mVBt = vPreBlank((mV + int'(videoPkg::V_TOTAL) - 2) % int'(videoPkg::V_TOTAL));
        end
        // register writes land after this edge
        if (wrEn) begin
            if (wrSel == videoPkg::SEL_HSCROLL && wrLayer < NUM_LAYERS) begin
                mHs[wrLayer] = wrData;
            end else if (wrSel == videoPkg::SEL_VSCROLL && wrLayer < NUM_LAYERS) begin
                mVs[wrLayer] = wrData;
            end else if (wrSel == videoPkg::SEL_PRIORITY) begin
                ok = 1;
                for (int s = 0; s < NUM_LAYERS; s++) begin
                    idx = (wrData >> (s * videoPkg::LAYER_W)) & 3;
                    newOrder[s] = idx;
                    if (idx >= NUM_LAYERS) ok = 0;
                end
                if (ok != 0) mPrio = newOrder;
            end
        end
    endtask

    task automatic driveRandom();
        int sel;
        int data;
        int j;
        int tmp;
        int perm [NUM_LAYERS];
        cen <= ($random(seed) & 3) != 0;
        if (($random(seed) & 63) == 0) begin
            sel = $random(seed) & 3;
            data = $random(seed) & 511;
            // half the priority writes carry a legal permutation
            if (sel == int'(videoPkg::SEL_PRIORITY) && ($random(seed) & 1) != 0) begin
                for (int i = 0; i < NUM_LAYERS; i++) perm[i] = i;
                for (int i = NUM_LAYERS - 1; i > 0; i--) begin
                    j = $unsigned($random(seed)) % (i + 1);
                    tmp = perm[i];
                    perm[i] = perm[j];
                    perm[j] = tmp;
                end
                data = 0;
                for (int i = 0; i < NUM_LAYERS; i++) begin
                    data = data | (perm[i] << (i * videoPkg::LAYER_W));
                end
            end
            wrEn <= 1'b1;
            wrSel <= videoPkg::SEL_W'(sel);
            wrLayer <= videoPkg::LAYER_W'($random(seed));
            wrData <= videoPkg::CNT_W'(data);
        end else begin
            wrEn <= 1'b0;
        end
    endtask

    task automatic checkOutputs();
        compareValue("hdump", hdump, mH);
        compareValue("vdump", vdump, mV);
        compareValue("vrender", vrender, nextLine(mV));
        compareValue("HS", HS, mHS);
        compareValue("VS", VS, mVS);
        compareValue("HB", HB, expHB);
        compareValue("VB", VB, expVB);
        compareValue("pixel", pixel, expPix);
        compareValue("pixelLayerOk", pixelLayerOk, expOk);
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        cen = 1'b0;
        wrEn = 1'b0;
        wrLayer = '0;
        wrSel = '0;
        wrData = '0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        // reset state
        compareValue("HS after reset", HS, 0);
        compareValue("VS after reset", VS, 0);
        compareValue("HB after reset", HB, 1);
        compareValue("VB after reset", VB, 1);
        compareValue("pixelLayerOk after reset", pixelLayerOk, 0);
        while (cenSteps < RUN_STEPS) begin
            @(posedge clk);
            stepModel();
            driveRandom();
            @(negedge clk);
            checkOutputs();
        end
        $display("%0d cen steps checked in %0d cycles", cenSteps, cycleCount);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- videoPkg.sv
/*
 * Shared constants of the raster video subsystem: frame geometry, counter
 * widths, sync and blanking positions, colour and pixel encodings.
 * Referenced by scoped name from the RTL and the testbench.
 */
`default_nettype none

package videoPkg;

    // pixel and line counters
    localparam int CNT_W = 9;
    // counter wraps at all ones
    localparam int H_TOTAL = 512;
    localparam logic [CNT_W-1:0] V_TOTAL = 9'd262;

    // horizontal blanking, high when hdump >= HB_START or hdump < HB_END
    localparam logic [CNT_W-1:0] HB_START = 9'd448;
    localparam logic [CNT_W-1:0] HB_END   = 9'd64;

    // vertical pre-blank, 224 visible lines in between
    localparam logic [CNT_W-1:0] VB_FIRST = 9'd14;
    localparam logic [CNT_W-1:0] VB_LAST  = 9'd237;

    // sync edges
    localparam logic [CNT_W-1:0] HS_START = 9'd478;
    localparam logic [CNT_W-1:0] HS_END   = 9'd18;
    // VS only moves at HS_START on these lines
    localparam logic [CNT_W-1:0] VS_START = 9'd251;
    localparam logic [CNT_W-1:0] VS_END   = 9'd255;

    // pattern colour
    localparam int COL_W = 4;
    localparam logic [COL_W-1:0] TRANSPARENT = 4'd0;

    // output pixel is {layer index, colour}
    localparam int LAYER_W = 2;
    localparam int PIX_W   = LAYER_W + COL_W;
    localparam logic [PIX_W-1:0] BLANK_PIX = '0;

    // register select codes of the write strobe
    localparam int SEL_W = 2;
    localparam logic [SEL_W-1:0] SEL_HSCROLL  = 2'd0;
    localparam logic [SEL_W-1:0] SEL_VSCROLL  = 2'd1;
    localparam logic [SEL_W-1:0] SEL_PRIORITY = 2'd2;

endpackage

`default_nettype wire

//--- videoTiming.sv
/*
 * Free-running raster timing generator for a 512 x 262 frame.
 * Advances one pixel on every clk with cen high, produces the dump and
 * render counters, HS/VS sync and HB/VB blanking.
 */
`default_nettype none

module videoTiming (
    input  wire                          clk,
    input  wire                          rstN,
    input  wire                          cen,
    output logic [videoPkg::CNT_W-1:0]   hdump,
    output logic [videoPkg::CNT_W-1:0]   vdump,
    output logic [videoPkg::CNT_W-1:0]   vrender,
    output logic                         HS,
    output logic                         VS,
    output logic                         HB,
    output logic                         VB,
    output logic                         preVB
);

    // two lines of lookahead over vdump
    logic [videoPkg::CNT_W-1:0] vrender1;
    // vertical blank shifter, bit 0 is the pre-blank flag
    logic [1:0] shVB;
    logic       lineEnd;

    assign preVB   = shVB[0];
    assign lineEnd = hdump == videoPkg::CNT_W'(videoPkg::H_TOTAL - 1);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hdump    <= '0;
            vdump    <= '0;
            vrender  <= 9'd1;
            vrender1 <= 9'd2;
            HS       <= 1'b0;
            VS       <= 1'b0;
            HB       <= 1'b1;
            VB       <= 1'b1;
            shVB     <= 2'b11;
        end else if (cen) begin
            // 9-bit counter wraps on its own at all ones
            hdump   <= hdump + 1'b1;
            shVB[0] <= vdump < videoPkg::VB_FIRST || vdump > videoPkg::VB_LAST;
            // registered one step after the hdump that sets it
            HB      <= hdump >= videoPkg::HB_START || hdump < videoPkg::HB_END;
            if (hdump == videoPkg::HS_START) begin
                HS <= 1'b1;
                // VS kept in step with the HS rising edge
                if (vdump == videoPkg::VS_START) begin
                    VS <= 1'b1;
                end
                if (vdump == videoPkg::VS_END) begin
                    VS <= 1'b0;
                end
            end
            if (hdump == videoPkg::HS_END) begin
                HS <= 1'b0;
            end
            if (lineEnd) begin
                vrender1 <= vrender1 == videoPkg::V_TOTAL - 1'b1 ? '0 : vrender1 + 1'b1;
                vrender  <= vrender1;
                vdump    <= vrender;
                // VB ends up two line wraps behind the pre-blank flag
                {VB, shVB[1]} <= shVB;
            end
        end
    end

    // VS only ever moves on the cen step taken at HS_START
    vsOnHsStart: assert property (
        @(posedge clk) disable iff (!rstN)
        !$stable(VS) |-> $past(cen) && $past(hdump) == videoPkg::HS_START
    ) else $error("VS changed away from HS_START");

endmodule

`default_nettype wire

//--- videoTop.sv
/*
 * Video subsystem top level: timing generator, scroll/priority registers,
 * NUM_LAYERS layer scanners and the pixel mixer.
 * pixel, HB and VB at the ports belong to the hdump of two cen steps earlier.
 */
`default_nettype none

module videoTop #(
    parameter int NUM_LAYERS = 3
) (
    input  wire                              clk,
    input  wire                              rstN,
    input  wire                              cen,
    input  wire                              wrEn,
    input  wire  [videoPkg::LAYER_W-1:0]     wrLayer,
    input  wire  [videoPkg::SEL_W-1:0]       wrSel,
    input  wire  [videoPkg::CNT_W-1:0]       wrData,
    output wire  [videoPkg::CNT_W-1:0]       hdump,
    output wire  [videoPkg::CNT_W-1:0]       vdump,
    output wire  [videoPkg::CNT_W-1:0]       vrender,
    output wire                              HS,
    output wire                              VS,
    output wire                              HB,
    output wire                              VB,
    output wire  [videoPkg::PIX_W-1:0]       pixel,
    output wire                              pixelLayerOk
);

    // blanking straight from the timing, one step before the mixer
    wire timingHB;
    wire timingVB;

    wire [NUM_LAYERS-1:0][videoPkg::CNT_W-1:0]   hScroll;
    wire [NUM_LAYERS-1:0][videoPkg::CNT_W-1:0]   vScroll;
    wire [NUM_LAYERS-1:0][videoPkg::LAYER_W-1:0] priorityOrder;
    wire [NUM_LAYERS-1:0][videoPkg::COL_W-1:0]   colour;

    // preVB has no consumer here
    videoTiming uTiming (
        .clk     (clk),
        .rstN    (rstN),
        .cen     (cen),
        .hdump   (hdump),
        .vdump   (vdump),
        .vrender (vrender),
        .HS      (HS),
        .VS      (VS),
        .HB      (timingHB),
        .VB      (timingVB),
        .preVB   ()
    );

    scrollRegs #(
        .NUM_LAYERS (NUM_LAYERS)
    ) uRegs (
        .clk           (clk),
        .rstN          (rstN),
        .wrEn          (wrEn),
        .wrLayer       (wrLayer),
        .wrSel         (wrSel),
        .wrData        (wrData),
        .hScroll       (hScroll),
        .vScroll       (vScroll),
        .priorityOrder (priorityOrder)
    );

    // one scanner per layer, index doubles as pattern offset
    for (genvar i = 0; i < NUM_LAYERS; i++) begin : gLayer
        layerScan #(
            .LAYER_ID (i)
        ) uScan (
            .clk     (clk),
            .rstN    (rstN),
            .cen     (cen),
            .hdump   (hdump),
            .vrender (vrender),
            .hScroll (hScroll[i]),
            .vScroll (vScroll[i]),
            .colour  (colour[i])
        );
    end

    pixelMixer #(
        .NUM_LAYERS (NUM_LAYERS)
    ) uMixer (
        .clk           (clk),
        .rstN          (rstN),
        .cen           (cen),
        .colour        (colour),
        .priorityOrder (priorityOrder),
        .HB            (timingHB),
        .VB            (timingVB),
        .pixel         (pixel),
        .pixelLayerOk  (pixelLayerOk),
        .HBout         (HB),
        .VBout         (VB)
    );

endmodule

`default_nettype wire
